/* dv/syndrome_checker.sv */
`timescale 1ns/1ps
`include "qec_defs.svh"

module syndrome_checker (
    input  logic                   clk,
    input  logic                   arst_n,
    input  logic [63:0]            seed,
    input  logic                   seed_load,
    input  logic [`QEC_PROB_W-1:0] prob,
    input  logic                   next,
    input  logic                   seed_ready,
    input  logic [`QEC_SYN_W-1:0]  syndrome,
    input  logic                   syndrome_valid,
    output int                     err_count,
    output int                     check_count,
    output int                     valid_count,
    output int                     pending
);

    localparam int NS        = `QEC_STREAM_COUNT;
    localparam int VER_BASE  = `QEC_HOR_COUNT;
    localparam int MEAS_BASE = `QEC_HOR_COUNT + `QEC_VER_COUNT;
    localparam logic [63:0] GAMMA = 64'h9E3779B97F4A7C15;

    logic [63:0]           st0 [NS];
    logic [63:0]           st1 [NS];
    logic [`QEC_ROUNDS:0]  err_bits [NS];
    logic [`QEC_SYN_W-1:0] exp_q [$];
    int                    cyc_q [$];
    logic [`QEC_SYN_W-1:0] exp_syn;
    int                    sent;
    int                    cycle;

    function automatic logic [63:0] splitmix_mix(input logic [63:0] x);
        logic [63:0] z;
        z = x;
        z = (z ^ (z >> 30)) * 64'hBF58476D1CE4E5B9;
        z = (z ^ (z >> 27)) * 64'h94D049BB133111EB;
        return z ^ (z >> 31);
    endfunction

    task automatic reseed_model(input logic [63:0] master);
        logic [63:0] ctr;
        int n;
        ctr = master;
        for (n = 0; n < NS; n++) begin
            ctr = ctr + GAMMA;
            st0[n] = splitmix_mix(ctr);
            ctr = ctr + GAMMA;
            st1[n] = splitmix_mix(ctr);
        end
    endtask

    // Thresholds the current output of every stream, then steps it.
    task automatic draw_model();
        logic [63:0] out;
        logic [63:0] t;
        int n;
        int r;
        for (n = 0; n < NS; n++) begin
            out = st0[n] + st1[n];
            err_bits[n] = '0;
            for (r = 0; r < `QEC_ROUNDS; r++) begin
                if (n < MEAS_BASE) begin
                    err_bits[n][r] = out[`QEC_PROB_W*r +: `QEC_PROB_W] < prob;
                end else if (r > 0) begin
                    err_bits[n][r] = out[`QEC_PROB_W*(r-1) +: `QEC_PROB_W] < prob;
                end
            end
            t = st0[n] ^ (st0[n] << 23);
            st0[n] = st1[n];
            st1[n] = t ^ (t >> 17) ^ st1[n] ^ (st1[n] >> 26);
        end
    endtask

    function automatic logic ver_bit(input int row, input int line, input int k);
        if (line == 0 || line == `QEC_DX) begin
            return 1'b0; // Open boundary.
        end
        return err_bits[VER_BASE + row * (`QEC_DX - 1) + line - 1][k];
    endfunction

    function automatic logic [`QEC_SYN_W-1:0] expected_syndrome();
        logic [`QEC_SYN_W-1:0] syn;
        int h;
        int m;
        syn = '0;
        for (int k = 0; k < `QEC_ROUNDS; k++) begin
            for (int i = 0; i < `QEC_DX; i++) begin
                for (int j = 0; j < `QEC_DZ; j++) begin
                    h = i * (`QEC_DZ + 1) + j;
                    m = MEAS_BASE + i * `QEC_DZ + j;
                    syn[i*`QEC_DZ + j + k*`QEC_DZ*`QEC_DX] =
                        err_bits[h][k] ^ err_bits[h+1][k] ^
                        ver_bit(j, i, k) ^ ver_bit(j, i + 1, k) ^
                        err_bits[m][k] ^ err_bits[m][k+1];
                end
            end
        end
        return syn;
    endfunction

    always @(negedge clk) begin
        if (!arst_n) begin
            exp_q.delete();
            cyc_q.delete();
            cycle = 0;
            err_count = 0;
            check_count = 0;
            valid_count = 0;
            pending = 0;
        end else begin
            cycle = cycle + 1;
            if (syndrome_valid) begin
                valid_count++;
                if (exp_q.size() == 0) begin
                    $display("time %0t: syndrome_valid pulsed with no draw pending", $time);
                    err_count++;
                end else begin
                    exp_syn = exp_q.pop_front();
                    sent = cyc_q.pop_front();
                    check_count++;
                    if (cycle - sent != 2) begin
                        $display("ERR %0t syndrome_valid latency expected 2 actual %0d",
                            $time, cycle - sent);
                        err_count++;
                    end
                    if (syndrome !== exp_syn) begin
                        $display("ERR %0t syndrome expected %h actual %h",
                            $time, exp_syn, syndrome);
                        err_count++;
                    end
                end
            end
            if (next && seed_ready) begin
                draw_model();
                exp_q.push_back(expected_syndrome());
                cyc_q.push_back(cycle);
            end
            if (seed_load) begin
                reseed_model(seed); // A draw in the same cycle still uses the old states.
            end
            pending = exp_q.size();
        end
    end

endmodule

/* dv/tb_top.sv */
`timescale 1ns/1ps
`include "qec_defs.svh"

module tb_top;

    logic                   clk;
    logic                   arst_n;
    logic [63:0]            seed;
    logic                   seed_load;
    logic [`QEC_PROB_W-1:0] prob;
    logic                   next;
    logic                   seed_ready;
    logic [`QEC_SYN_W-1:0]  syndrome;
    logic                   syndrome_valid;
    int                     err_count;
    int                     check_count;
    int                     valid_count;
    int                     pending;
    integer                 rand_seed;
    int                     local_errs;
    int                     tests_run;
    int                     tests_failed;
    int                     errs_before;
    int                     latency;
    int                     valid_before;

    always #5 clk = ~clk;

    qec_error_gen_top DUT (
        .clk(clk), .arst_n(arst_n),
        .seed(seed), .seed_load(seed_load),
        .prob(prob), .next(next),
        .seed_ready(seed_ready),
        .syndrome(syndrome), .syndrome_valid(syndrome_valid)
    );

    syndrome_checker u_checker (
        .clk(clk), .arst_n(arst_n),
        .seed(seed), .seed_load(seed_load),
        .prob(prob), .next(next),
        .seed_ready(seed_ready),
        .syndrome(syndrome), .syndrome_valid(syndrome_valid),
        .err_count(err_count), .check_count(check_count),
        .valid_count(valid_count), .pending(pending)
    );

    task automatic next_cycle();
        @(posedge clk);
        #1;
    endtask

    task automatic idle(input int n);
        repeat (n) next_cycle();
    endtask

    task automatic check_value(input string name, input longint expected, input longint actual);
        if (expected != actual) begin
            $display("ERR %0t %s expected %0d actual %0d", $time, name, expected, actual);
            local_errs++;
        end
    endtask

    task automatic end_test(input string name);
        int n;
        n = err_count + local_errs - errs_before;
        tests_run++;
        if (n == 0) begin
            $display("test %0d, %s: ok", tests_run, name);
        end else begin
            tests_failed++;
            $display("test %0d, %s: %0d errors", tests_run, name, n);
        end
        errs_before = err_count + local_errs;
    endtask

    // Latency counts cycles from the one that carries seed_load.
    task automatic load_seed(input logic [63:0] value, input bit stray_next);
        seed = value;
        seed_load = 1'b1;
        next_cycle();
        seed_load = 1'b0;
        latency = 1;
        while (!seed_ready && latency < 100) begin
            next = stray_next && (latency == 3);
            next_cycle();
            latency++;
        end
        next = 1'b0;
        if (!seed_ready) begin
            $display("time %0t: seed_ready never rose after seed_load", $time);
            local_errs++;
        end
    endtask

    task automatic draw(input bit expect_zero);
        int waited;
        next = 1'b1;
        next_cycle();
        next = 1'b0;
        waited = 0;
        while (!syndrome_valid && waited < 8) begin
            next_cycle();
            waited++;
        end
        if (!syndrome_valid) begin
            $display("time %0t: no syndrome_valid followed a draw", $time);
            local_errs++;
        end else if (expect_zero && syndrome != '0) begin
            $display("ERR %0t syndrome expected 0 actual %h", $time, syndrome);
            local_errs++;
        end
    endtask

    task automatic drain();
        int waited;
        waited = 0;
        while (pending != 0 && waited < 20) begin
            next_cycle();
            waited++;
        end
        if (pending != 0) begin
            $display("time %0t: %0d expected syndromes never arrived", $time, pending);
            local_errs++;
        end
    endtask

    initial begin
        clk = 1'b0;
        arst_n = 1'b0;
        seed = '0;
        seed_load = 1'b0;
        prob = '0;
        next = 1'b0;
        rand_seed = 32'hcbbe;
        local_errs = 0;
        tests_run = 0;
        tests_failed = 0;
        repeat (8) @(posedge clk);
        #1;
        arst_n = 1'b1;
        idle(2);
        errs_before = err_count + local_errs;

        check_value("syndrome_valid", 0, syndrome_valid);
        check_value("seed_ready", 0, seed_ready);
        load_seed({32'($random(rand_seed)), 32'($random(rand_seed))}, 1'b0);
        check_value("seed_ready latency", 62, latency);
        end_test("reset and seeding");

        prob = '0;
        repeat (10) draw(1'b1);
        drain();
        end_test("zero probability");

        prob = `QEC_PROB_W'($random(rand_seed));
        repeat (50) begin
            draw(1'b0);
            idle($random(rand_seed) & 3);
        end
        drain();
        end_test("random draws with gaps");

        valid_before = valid_count;
        next = 1'b1;
        idle(20);
        next = 1'b0;
        drain();
        check_value("syndrome_valid count", 20, valid_count - valid_before);
        end_test("back-to-back draws");

        valid_before = valid_count;
        load_seed({32'($random(rand_seed)), 32'($random(rand_seed))}, 1'b1);
        idle(4);
        check_value("syndrome_valid count", 0, valid_count - valid_before);
        check_value("seed_ready latency", 62, latency);
        repeat (20) begin
            draw(1'b0);
            idle($random(rand_seed) & 3);
        end
        drain();
        end_test("reseed");

        $display("%0d tests run, %0d failed, %0d syndromes compared, %0d errors",
            tests_run, tests_failed, check_count, err_count + local_errs);
        if (tests_failed == 0 && err_count + local_errs == 0) begin
            $display("all tests passed");
        end else begin
            $display("tests failed");
        end
        $finish;
    end

    initial begin
        #200000;
        $display("time %0t: simulation watchdog expired", $time);
        $display("tests failed");
        $finish;
    end

endmodule

/* files.f */
+incdir+verilog
verilog/qec_pkg.sv
verilog/seed_expander.sv
verilog/error_stream.sv
verilog/error_lattice.sv
verilog/syndrome_builder.sv
verilog/qec_error_gen_top.sv
dv/syndrome_checker.sv
dv/tb_top.sv

/* run_sim.sh */
#!/bin/sh
cd "$(dirname "$0")" || exit 1
log=sim.log

verilator --binary --timing --assert -Wno-fatal -f files.f --top-module tb_top -o tb_top_sim
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

./obj_dir/tb_top_sim > "$log" 2>&1
status=$?
cat "$log"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -q "tests failed" "$log"; then
    echo "result: FAIL"
    exit 1
fi
echo "result: PASS"
exit 0

/* verilog/error_lattice.sv */
`timescale 1ns/1ps
`include "qec_defs.svh"

module error_lattice import qec_pkg::*; (
    input  logic                                   clk,
    input  logic                                   arst_n,
    input  logic                                   seed_we,
    input  logic [`QEC_IDX_W-1:0]                  seed_idx,
    input  logic [63:0]                            seed_s0,
    input  logic [63:0]                            seed_s1,
    input  logic                                   next,
    input  logic [`QEC_PROB_W-1:0]                 prob,
    output logic [`QEC_HOR_COUNT*`QEC_ERR_W-1:0]   hor_err,
    output logic [`QEC_VER_LINES*`QEC_ERR_W-1:0]   ver_err,
    output logic [`QEC_MEAS_COUNT*`QEC_ERR_W-1:0]  meas_err,
    output logic                                   err_valid
);

    localparam int EW = `QEC_ERR_W;
    localparam logic [`QEC_IDX_W-1:0] LAST_IDX = `QEC_IDX_W'(`QEC_STREAM_COUNT - 1);

    logic ready_q;
    logic advance;
    logic next_d;

    assign advance   = next && ready_q && !seed_we;
    assign err_valid = next_d; // Error words are valid one cycle after the draw.

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            ready_q <= 1'b0;
            next_d  <= 1'b0;
        end else begin
            if (seed_we) begin
                ready_q <= (seed_idx == LAST_IDX); // Set by the final write of a walk.
            end
            next_d <= advance;
        end
    end

    for (genvar i = 0; i < `QEC_DX; i++) begin : g_hor_i
        for (genvar j = 0; j <= `QEC_DZ; j++) begin : g_j
            localparam int H = i * (`QEC_DZ + 1) + j;
            error_stream #(.IDX(H), .KIND(STREAM_DATA)) u_stream (
                .clk(clk), .arst_n(arst_n),
                .seed_we(seed_we), .seed_idx(seed_idx),
                .seed_s0(seed_s0), .seed_s1(seed_s1),
                .advance(advance), .prob(prob),
                .err(hor_err[H*EW +: EW])
            );
        end
    end

    for (genvar i = 0; i < `QEC_DZ; i++) begin : g_ver_i
        for (genvar j = 0; j <= `QEC_DX; j++) begin : g_j
            localparam int L = i * (`QEC_DX + 1) + j;
            if (j > 0 && j < `QEC_DX) begin : g_line
                error_stream #(
                    .IDX(`QEC_HOR_COUNT + i * (`QEC_DX - 1) + j - 1),
                    .KIND(STREAM_DATA)
                ) u_stream (
                    .clk(clk), .arst_n(arst_n),
                    .seed_we(seed_we), .seed_idx(seed_idx),
                    .seed_s0(seed_s0), .seed_s1(seed_s1),
                    .advance(advance), .prob(prob),
                    .err(ver_err[L*EW +: EW])
                );
            end else begin : g_edge
                assign ver_err[L*EW +: EW] = '0; // Open boundary.
            end
        end
    end

    for (genvar i = 0; i < `QEC_DX; i++) begin : g_meas_i
        for (genvar j = 0; j < `QEC_DZ; j++) begin : g_j
            localparam int M = i * `QEC_DZ + j;
            error_stream #(
                .IDX(`QEC_HOR_COUNT + `QEC_VER_COUNT + M),
                .KIND(STREAM_MEAS)
            ) u_stream (
                .clk(clk), .arst_n(arst_n),
                .seed_we(seed_we), .seed_idx(seed_idx),
                .seed_s0(seed_s0), .seed_s1(seed_s1),
                .advance(advance), .prob(prob),
                .err(meas_err[M*EW +: EW])
            );
        end
    end

endmodule

/* verilog/error_stream.sv */
`timescale 1ns/1ps
`include "qec_defs.svh"

module error_stream import qec_pkg::*; #(
    parameter int           IDX  = 0,
    parameter stream_kind_t KIND = STREAM_DATA
) (
    input  logic                   clk,
    input  logic                   arst_n,
    input  logic                   seed_we,
    input  logic [`QEC_IDX_W-1:0]  seed_idx,
    input  logic [63:0]            seed_s0,
    input  logic [63:0]            seed_s1,
    input  logic                   advance,
    input  logic [`QEC_PROB_W-1:0] prob,
    output logic [`QEC_ROUNDS:0]   err
);

    localparam logic [`QEC_IDX_W-1:0] OWN_IDX = `QEC_IDX_W'(IDX);

    logic [63:0] s0;
    logic [63:0] s1;
    logic [63:0] rnd;
    logic [63:0] t;
    logic [`QEC_ROUNDS:0] hit;
    logic load;

    assign load = seed_we && (seed_idx == OWN_IDX);
    assign rnd  = s0 + s1; // Output comes from the state before the step.
    assign t    = s0 ^ (s0 << 23);

    for (genvar r = 0; r <= `QEC_ROUNDS; r++) begin : g_round
        if (KIND == STREAM_DATA && r < `QEC_ROUNDS) begin : g_data
            assign hit[r] = rnd[`QEC_PROB_W*r +: `QEC_PROB_W] < prob;
        end else if (KIND == STREAM_MEAS && r >= 1 && r < `QEC_ROUNDS) begin : g_meas
            assign hit[r] = rnd[`QEC_PROB_W*(r-1) +: `QEC_PROB_W] < prob;
        end else begin : g_zero
            assign hit[r] = 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (load) begin
            s0 <= seed_s0;
            s1 <= seed_s1;
        end else if (advance) begin
            s0 <= s1;
            s1 <= t ^ (t >> 17) ^ s1 ^ (s1 >> 26);
        end
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            err <= '0;
        end else if (advance) begin
            err <= hit;
        end
    end

    // The lattice must hold advance off while this stream is seeded.
    assert property (@(posedge clk) disable iff (!arst_n) load |-> !advance)
        else $error("stream %0d seeded and advanced in the same cycle", IDX);

endmodule

/* verilog/qec_defs.svh */
`ifndef QEC_DEFS_SVH
`define QEC_DEFS_SVH

`define QEC_DX 5
`define QEC_DZ 4
`define QEC_ROUNDS ((`QEC_DX > `QEC_DZ) ? `QEC_DX : `QEC_DZ)

`define QEC_HOR_COUNT (`QEC_DX * (`QEC_DZ + 1))
`define QEC_VER_COUNT (`QEC_DZ * (`QEC_DX - 1))
`define QEC_MEAS_COUNT (`QEC_DX * `QEC_DZ)
`define QEC_STREAM_COUNT (`QEC_HOR_COUNT + `QEC_VER_COUNT + `QEC_MEAS_COUNT)
`define QEC_VER_LINES (`QEC_DZ * (`QEC_DX + 1))

`define QEC_SYN_W (`QEC_DX * `QEC_DZ * `QEC_ROUNDS)
`define QEC_ERR_W (`QEC_ROUNDS + 1)
`define QEC_PROB_W 12
`define QEC_IDX_W 6
`endif

/* verilog/qec_error_gen_top.sv */
`timescale 1ns/1ps
`include "qec_defs.svh"

module qec_error_gen_top (
    input  logic                   clk,
    input  logic                   arst_n,
    input  logic [63:0]            seed,
    input  logic                   seed_load,
    input  logic [`QEC_PROB_W-1:0] prob,
    input  logic                   next,
    output logic                   seed_ready,
    output logic [`QEC_SYN_W-1:0]  syndrome,
    output logic                   syndrome_valid
);

    logic                                  seed_we;
    logic [`QEC_IDX_W-1:0]                 seed_idx;
    logic [63:0]                           seed_s0;
    logic [63:0]                           seed_s1;
    logic [`QEC_HOR_COUNT*`QEC_ERR_W-1:0]  hor_err;
    logic [`QEC_VER_LINES*`QEC_ERR_W-1:0]  ver_err;
    logic [`QEC_MEAS_COUNT*`QEC_ERR_W-1:0] meas_err;
    logic                                  err_valid;

    seed_expander u_seed_expander (
        .clk(clk), .arst_n(arst_n),
        .seed(seed), .seed_load(seed_load),
        .seed_we(seed_we), .seed_idx(seed_idx),
        .seed_s0(seed_s0), .seed_s1(seed_s1),
        .seed_ready(seed_ready)
    );

    error_lattice u_error_lattice (
        .clk(clk), .arst_n(arst_n),
        .seed_we(seed_we), .seed_idx(seed_idx),
        .seed_s0(seed_s0), .seed_s1(seed_s1),
        .next(next), .prob(prob),
        .hor_err(hor_err), .ver_err(ver_err), .meas_err(meas_err),
        .err_valid(err_valid)
    );

    syndrome_builder u_syndrome_builder (
        .clk(clk), .arst_n(arst_n),
        .hor_err(hor_err), .ver_err(ver_err), .meas_err(meas_err),
        .err_valid(err_valid),
        .syndrome(syndrome), .syndrome_valid(syndrome_valid)
    );

endmodule

/* verilog/qec_pkg.sv */
package qec_pkg;

    // Seed expander FSM.
    typedef enum logic [1:0] {
        SEED_IDLE = 2'd0,
        SEED_WALK = 2'd1,
        SEED_DONE = 2'd2
    } seed_state_t;

    // Data edges carry errors in every round.
    // Measurement edges only between rounds, so their first and last slots stay zero.
    typedef enum logic {
        STREAM_DATA = 1'b0,
        STREAM_MEAS = 1'b1
    } stream_kind_t;

endpackage

/* verilog/seed_expander.sv */
`timescale 1ns/1ps
`include "qec_defs.svh"

module seed_expander import qec_pkg::*; (
    input  logic                  clk,
    input  logic                  arst_n,
    input  logic [63:0]           seed,
    input  logic                  seed_load,
    output logic                  seed_we,
    output logic [`QEC_IDX_W-1:0] seed_idx,
    output logic [63:0]           seed_s0,
    output logic [63:0]           seed_s1,
    output logic                  seed_ready
);

    localparam logic [63:0] GOLDEN_GAMMA = 64'h9E3779B97F4A7C15;
    localparam logic [`QEC_IDX_W-1:0] LAST_IDX = `QEC_IDX_W'(`QEC_STREAM_COUNT - 1);

    seed_state_t state;
    logic [63:0] ctr;
    logic [63:0] ctr_a;
    logic [63:0] ctr_b;

    function automatic logic [63:0] mix64(input logic [63:0] x);
        logic [63:0] z;
        z = (x ^ (x >> 30)) * 64'hBF58476D1CE4E5B9;
        z = (z ^ (z >> 27)) * 64'h94D049BB133111EB;
        return z ^ (z >> 31);
    endfunction

    assign ctr_a      = ctr + GOLDEN_GAMMA; // Two splitmix draws per stream.
    assign ctr_b      = ctr_a + GOLDEN_GAMMA;
    assign seed_s0    = mix64(ctr_a);
    assign seed_s1    = mix64(ctr_b);
    assign seed_ready = (state == SEED_DONE);

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            state    <= SEED_IDLE;
            seed_we  <= 1'b0;
            seed_idx <= '0;
        end else if (seed_load) begin
            state    <= SEED_WALK; // A new seed restarts the walk at any time.
            seed_we  <= 1'b1;
            seed_idx <= '0;
        end else if (state == SEED_WALK) begin
            seed_idx <= seed_idx + 1'b1;
            if (seed_idx == LAST_IDX) begin
                state   <= SEED_DONE;
                seed_we <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (seed_load) begin
            ctr <= seed;
        end else if (seed_we) begin
            ctr <= ctr_b;
        end
    end

    assert property (@(posedge clk) disable iff (!arst_n) seed_we |-> state == SEED_WALK)
        else $error("seed_we high outside the seed walk");

endmodule

/* verilog/syndrome_builder.sv */
`timescale 1ns/1ps
`include "qec_defs.svh"

module syndrome_builder (
    input  logic                                   clk,
    input  logic                                   arst_n,
    input  logic [`QEC_HOR_COUNT*`QEC_ERR_W-1:0]   hor_err,
    input  logic [`QEC_VER_LINES*`QEC_ERR_W-1:0]   ver_err,
    input  logic [`QEC_MEAS_COUNT*`QEC_ERR_W-1:0]  meas_err,
    input  logic                                   err_valid,
    output logic [`QEC_SYN_W-1:0]                  syndrome,
    output logic                                   syndrome_valid
);

    localparam int EW = `QEC_ERR_W;

    logic [`QEC_SYN_W-1:0] syn_next;

    for (genvar k = 0; k < `QEC_ROUNDS; k++) begin : g_k
        for (genvar i = 0; i < `QEC_DX; i++) begin : g_i
            for (genvar j = 0; j < `QEC_DZ; j++) begin : g_j
                localparam int H = i * (`QEC_DZ + 1) + j;
                localparam int V = j * (`QEC_DX + 1) + i; // Lines i and i+1 of row j.
                localparam int M = i * `QEC_DZ + j;
                assign syn_next[i*`QEC_DZ + j + k*`QEC_DZ*`QEC_DX] =
                    hor_err[H*EW + k] ^ hor_err[(H+1)*EW + k] ^
                    ver_err[V*EW + k] ^ ver_err[(V+1)*EW + k] ^
                    meas_err[M*EW + k] ^ meas_err[M*EW + k + 1];
            end
        end
    end

    always_ff @(posedge clk) begin
        if (err_valid) begin
            syndrome <= syn_next;
        end
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            syndrome_valid <= 1'b0;
        end else begin
            syndrome_valid <= err_valid;
        end
    end

endmodule
